// ==== include/lpif_link_params.svh ====
/*
 * Logic-link size parameters
 * Data width, lane count and lane layout shared by RTL and testbench
 */
`ifndef LPIF_LINK_PARAMS_SVH
`define LPIF_LINK_PARAMS_SVH

// Upstream and downstream data field width
`define LPIF_DATA_W 64

// PHY lanes per link, lane mapping assumes exactly four
`define LPIF_LANES 4

// Width of one PHY lane word
`define LPIF_PHY_W 40

// Marker user bits per lane, just above the payload
`define LPIF_MRK_W 2

// Strobe user bit sits at the top of each lane
`define LPIF_STB_BIT (`LPIF_PHY_W - 1)

`endif

// ==== source/lpif_link_pkg.sv ====
/*
 * Logic-link types
 * Link word layout, lane payload and sync counter types
 */
`include "lpif_link_params.svh"

package lpif_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Link word

  // One beat, first member lands in the top bits
  typedef struct packed {
    logic [3:0]              state;
    logic [1:0]              protid;
    logic [`LPIF_DATA_W-1:0] data;
    logic                    dvalid;
    logic [15:0]             crc;
    logic                    crc_valid;
    logic                    valid;
  } llink_word_t;

  localparam int LLINK_W = $bits(llink_word_t);

  ////////////////////////////////////////////////////////////////////////////
  // Lanes

  // Lane minus marker bits minus strobe bit
  localparam int LANE_PAYLOAD_W = `LPIF_PHY_W - `LPIF_MRK_W - 1;
  // Payload span of all lanes together, link word in the low bits
  localparam int LANE_SPAN_W    = LANE_PAYLOAD_W * `LPIF_LANES;

  typedef logic [LANE_PAYLOAD_W-1:0] lane_payload_t;
  typedef logic [LANE_SPAN_W-1:0]    lane_span_t;

  // Online delay counter, holds up to 255 + 255 + 1
  typedef logic [8:0] sync_cnt_t;

endpackage

// ==== source/lpif_link_user_if.sv ====
/*
 * Logic-link user interface
 * Registers downstream fields into a link word and unpacks
 * received link words onto the upstream ports
 */
`timescale 1ns/1ps
`include "lpif_link_params.svh"

module lpif_link_user_if import lpif_link_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    reset,

  // Downstream beat from protocol layer
  input  logic [3:0]              dstrm_state,
  input  logic [1:0]              dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0] dstrm_data,
  input  logic                    dstrm_dvalid,
  input  logic [15:0]             dstrm_crc,
  input  logic                    dstrm_crc_valid,
  input  logic                    dstrm_valid,

  // Link words toward and from the lane mapping
  output llink_word_t             tx_word,
  input  llink_word_t             rx_word,
  input  logic                    rx_online_delay,

  // Upstream beat to protocol layer
  output logic [3:0]              ustrm_state,
  output logic [1:0]              ustrm_protid,
  output logic [`LPIF_DATA_W-1:0] ustrm_data,
  output logic                    ustrm_dvalid,
  output logic [15:0]             ustrm_crc,
  output logic                    ustrm_crc_valid,
  output logic                    ustrm_valid
);

  // Registered upstream beat
  llink_word_t ustrm_word;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit

  // One beat per cycle, no back-pressure
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_word <= '0;
    end else begin
      tx_word.state     <= dstrm_state;
      tx_word.protid    <= dstrm_protid;
      tx_word.data      <= dstrm_data;
      tx_word.dvalid    <= dstrm_dvalid;
      tx_word.crc       <= dstrm_crc;
      tx_word.crc_valid <= dstrm_crc_valid;
      tx_word.valid     <= dstrm_valid;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive

  // Nothing passes up until the receive side is synced
  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online_delay) begin
      ustrm_word <= '0;
    end else begin
      ustrm_word <= rx_word;
    end
  end

  // Field split
  assign ustrm_state     = ustrm_word.state;
  assign ustrm_protid    = ustrm_word.protid;
  assign ustrm_data      = ustrm_word.data;
  assign ustrm_dvalid    = ustrm_word.dvalid;
  assign ustrm_crc       = ustrm_word.crc;
  assign ustrm_crc_valid = ustrm_word.crc_valid;
  assign ustrm_valid     = ustrm_word.valid;

endmodule

// ==== source/lpif_link_auto_sync.sv ====
/*
 * Logic-link auto sync
 * Delays tx_online and rx_online by programmable counts and
 * generates marker and strobe user bits once transmit is online
 */
`timescale 1ns/1ps
`include "lpif_link_params.svh"

module lpif_link_auto_sync import lpif_link_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   reset,

  // Raw online levels
  input  logic                   tx_online,
  input  logic                   rx_online,

  // Delay configuration
  input  logic [7:0]             delay_x_value,
  input  logic [7:0]             delay_xz_value,
  input  logic [7:0]             delay_yz_value,

  // User-bit configuration
  input  logic [`LPIF_MRK_W-1:0] tx_mrk_userbit,
  input  logic                   tx_stb_userbit,

  output logic                   tx_online_delay,
  output logic                   rx_online_delay,
  output logic [`LPIF_MRK_W-1:0] auto_mrk_userbit,
  output logic                   auto_stb_userbit
);

  sync_cnt_t tx_cnt;
  sync_cnt_t rx_cnt;
  sync_cnt_t tx_target;
  sync_cnt_t rx_target;
  logic      tx_reached;
  logic      rx_reached;

  // Count up, hold at all ones
  function automatic sync_cnt_t sat_inc(input sync_cnt_t cnt);
    sync_cnt_t res;
    res = cnt;
    if (cnt != '1) begin
      res = cnt + sync_cnt_t'(1);
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Delay counters

  // Counts edges with online high and restarts while low
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      tx_cnt <= '0;
    end else begin
      tx_cnt <= sat_inc(tx_cnt);
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online) begin
      rx_cnt <= '0;
    end else begin
      rx_cnt <= sat_inc(rx_cnt);
    end
  end

  // Targets are the delay sums plus one
  assign tx_target = {1'b0, delay_xz_value} + 9'd1;
  assign rx_target = {1'b0, delay_x_value} + {1'b0, delay_yz_value} + 9'd1;

  assign tx_reached = tx_online && (tx_cnt >= tx_target);
  assign rx_reached = rx_online && (rx_cnt >= rx_target);

  ////////////////////////////////////////////////////////////////////////////
  // Outputs

  // User bits follow tx_online_delay cycle for cycle
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_online_delay  <= 1'b0;
      rx_online_delay  <= 1'b0;
      auto_mrk_userbit <= '0;
      auto_stb_userbit <= 1'b0;
    end else begin
      tx_online_delay  <= tx_reached;
      rx_online_delay  <= rx_reached;
      auto_mrk_userbit <= tx_reached ? tx_mrk_userbit : '0;
      auto_stb_userbit <= tx_reached & tx_stb_userbit;
    end
  end

endmodule

// ==== source/lpif_link_concat.sv ====
/*
 * Logic-link lane mapping
 * Slices link words across four PHY lanes with user bits and
 * rebuilds received link words from the lanes
 */
`timescale 1ns/1ps
`include "lpif_link_params.svh"

module lpif_link_concat import lpif_link_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   reset,

  // Transmit link word and online state
  input  llink_word_t            tx_word,
  input  logic                   tx_online_delay,
  input  logic [`LPIF_MRK_W-1:0] auto_mrk_userbit,
  input  logic                   auto_stb_userbit,

  // PHY lanes out
  output logic [`LPIF_PHY_W-1:0] tx_phy0,
  output logic [`LPIF_PHY_W-1:0] tx_phy1,
  output logic [`LPIF_PHY_W-1:0] tx_phy2,
  output logic [`LPIF_PHY_W-1:0] tx_phy3,

  // PHY lanes in
  input  logic [`LPIF_PHY_W-1:0] rx_phy0,
  input  logic [`LPIF_PHY_W-1:0] rx_phy1,
  input  logic [`LPIF_PHY_W-1:0] rx_phy2,
  input  logic [`LPIF_PHY_W-1:0] rx_phy3,

  // Rebuilt receive link word
  output llink_word_t            rx_word
);

  lane_span_t tx_span;
  lane_span_t rx_span;

  // Lane layout, strobe on top, marker next, payload below
  function automatic logic [`LPIF_PHY_W-1:0] pack_lane(
    input lane_payload_t          pay,
    input logic [`LPIF_MRK_W-1:0] mrk,
    input logic                   stb
  );
    logic [`LPIF_PHY_W-1:0] lane;
    lane = '0;
    lane[LANE_PAYLOAD_W-1:0]            = pay;
    lane[LANE_PAYLOAD_W +: `LPIF_MRK_W] = mrk;
    lane[`LPIF_STB_BIT]                 = stb;
    return lane;
  endfunction

  // Payload only, user bits dropped
  function automatic lane_payload_t strip_lane(input logic [`LPIF_PHY_W-1:0] lane);
    return lane[LANE_PAYLOAD_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Transmit

  // Link word in low bits, padding above is zero
  assign tx_span = {{(LANE_SPAN_W - LLINK_W){1'b0}}, tx_word};

  // Lanes stay quiet until transmit side is online
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online_delay) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
      tx_phy2 <= '0;
      tx_phy3 <= '0;
    end else begin
      tx_phy0 <= pack_lane(tx_span[0*LANE_PAYLOAD_W +: LANE_PAYLOAD_W],
                           auto_mrk_userbit, auto_stb_userbit);
      tx_phy1 <= pack_lane(tx_span[1*LANE_PAYLOAD_W +: LANE_PAYLOAD_W],
                           auto_mrk_userbit, auto_stb_userbit);
      tx_phy2 <= pack_lane(tx_span[2*LANE_PAYLOAD_W +: LANE_PAYLOAD_W],
                           auto_mrk_userbit, auto_stb_userbit);
      tx_phy3 <= pack_lane(tx_span[3*LANE_PAYLOAD_W +: LANE_PAYLOAD_W],
                           auto_mrk_userbit, auto_stb_userbit);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive

  // Lane 0 holds the lowest payload slice
  assign rx_span = {strip_lane(rx_phy3), strip_lane(rx_phy2),
                    strip_lane(rx_phy1), strip_lane(rx_phy0)};

  // Padding bits above the link word are ignored
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_word <= '0;
    end else begin
      rx_word <= llink_word_t'(rx_span[LLINK_W-1:0]);
    end
  end

endmodule

// ==== source/lpif_link_top.sv ====
/*
 * Logic-link master top
 * Four-lane die-to-die link, no FIFO and no credits
 */
`timescale 1ns/1ps
`include "lpif_link_params.svh"

module lpif_link_top import lpif_link_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    reset,

  // Online control
  input  logic                    tx_online,
  input  logic                    rx_online,

  // PHY interconnect
  output logic [`LPIF_PHY_W-1:0]  tx_phy0,
  output logic [`LPIF_PHY_W-1:0]  tx_phy1,
  output logic [`LPIF_PHY_W-1:0]  tx_phy2,
  output logic [`LPIF_PHY_W-1:0]  tx_phy3,
  input  logic [`LPIF_PHY_W-1:0]  rx_phy0,
  input  logic [`LPIF_PHY_W-1:0]  rx_phy1,
  input  logic [`LPIF_PHY_W-1:0]  rx_phy2,
  input  logic [`LPIF_PHY_W-1:0]  rx_phy3,

  // Downstream channel
  input  logic [3:0]              dstrm_state,
  input  logic [1:0]              dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0] dstrm_data,
  input  logic                    dstrm_dvalid,
  input  logic [15:0]             dstrm_crc,
  input  logic                    dstrm_crc_valid,
  input  logic                    dstrm_valid,

  // Upstream channel
  output logic [3:0]              ustrm_state,
  output logic [1:0]              ustrm_protid,
  output logic [`LPIF_DATA_W-1:0] ustrm_data,
  output logic                    ustrm_dvalid,
  output logic [15:0]             ustrm_crc,
  output logic                    ustrm_crc_valid,
  output logic                    ustrm_valid,

  // Configuration
  input  logic [`LPIF_MRK_W-1:0]  tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  input  logic [7:0]              delay_x_value,
  input  logic [7:0]              delay_xz_value,
  input  logic [7:0]              delay_yz_value
);

  llink_word_t            tx_word;
  llink_word_t            rx_word;
  logic                   tx_online_delay;
  logic                   rx_online_delay;
  logic [`LPIF_MRK_W-1:0] auto_mrk_userbit;
  logic                   auto_stb_userbit;

  // Online delays and user bits
  lpif_link_auto_sync u_auto_sync (.*);

  // Protocol-side fields
  lpif_link_user_if u_user_if (.*);

  // Lane slicing and rebuild
  lpif_link_concat u_concat (.*);

endmodule

// ==== bench/lpif_link_assertions.sv ====
/*
 * Logic-link bound assertions
 * Quiet lanes and upstream ports while offline, clean reset
 */
`timescale 1ns/1ps
`include "lpif_link_params.svh"

module lpif_link_assertions (
  input logic                   clk_wr,
  input logic                   reset,
  input logic                   tx_online_delay,
  input logic                   rx_online_delay,
  input logic [`LPIF_PHY_W-1:0] tx_phy0,
  input logic [`LPIF_PHY_W-1:0] tx_phy1,
  input logic [`LPIF_PHY_W-1:0] tx_phy2,
  input logic [`LPIF_PHY_W-1:0] tx_phy3,
  input logic                   ustrm_valid
);

  // Lanes are registered, so they clear one edge after the delay is seen low
  a_tx_quiet: assert property (@(posedge clk_wr) disable iff (reset)
    !tx_online_delay |=> (tx_phy0 == '0) && (tx_phy1 == '0) &&
                         (tx_phy2 == '0) && (tx_phy3 == '0))
    else $error("tx_phy lanes carry data while tx_online_delay is low");

  // Same for the upstream register
  a_rx_quiet: assert property (@(posedge clk_wr) disable iff (reset)
    !rx_online_delay |=> !ustrm_valid)
    else $error("ustrm_valid high while rx_online_delay is low");

  a_reset_offline: assert property (@(posedge clk_wr)
    reset |=> !tx_online_delay && !rx_online_delay)
    else $error("online delay high in the cycle after reset");

endmodule

bind lpif_link_top lpif_link_assertions u_assertions (.*);

// ==== bench/lpif_link_tb.sv ====
/*
 * Logic-link loopback testbench
 * Lanes wired back into the receive side, table beats checked on
 * the lanes and on the upstream ports
 */
`timescale 1ns/1ps
`include "lpif_link_params.svh"

module lpif_link_tb;

  localparam int DATA_W      = `LPIF_DATA_W;
  localparam int PHY_W       = `LPIF_PHY_W;
  localparam int MRK_W       = `LPIF_MRK_W;
  localparam int PAY_W       = PHY_W - MRK_W - 1;
  localparam int SPAN_W      = PAY_W * `LPIF_LANES;
  localparam int WORD_W      = 4 + 2 + DATA_W + 1 + 16 + 1 + 1;
  localparam int CLK_PERIOD  = 4;
  localparam int DRIVE_DLY   = 1;
  localparam int DLY_X       = 3;
  localparam int DLY_XZ      = 5;
  localparam int DLY_YZ      = 4;
  localparam int NUM_ROWS    = 10;
  localparam int RAMP_STEPS  = 14;
  localparam int WATCHDOG_NS = (2 * NUM_ROWS + DLY_X + DLY_XZ + DLY_YZ + 200) * CLK_PERIOD;

  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic        dvalid;
    logic [15:0] crc;
    logic        crc_valid;
    logic        valid;
  } row_t;

  // state, protid, dvalid, crc, crc_valid, valid
  localparam row_t ROWS [NUM_ROWS] = '{
    '{4'h1, 2'd0, 1'b1, 16'h1d0f, 1'b1, 1'b1},
    '{4'h2, 2'd1, 1'b1, 16'hbeef, 1'b0, 1'b1},
    '{4'h3, 2'd2, 1'b0, 16'h0000, 1'b0, 1'b0},
    '{4'hf, 2'd3, 1'b1, 16'hffff, 1'b1, 1'b1},
    '{4'h0, 2'd0, 1'b0, 16'h8001, 1'b1, 1'b0},
    '{4'h9, 2'd1, 1'b1, 16'h4c3a, 1'b1, 1'b1},
    '{4'h5, 2'd2, 1'b1, 16'h7e81, 1'b0, 1'b0},
    '{4'ha, 2'd3, 1'b0, 16'h0f0f, 1'b1, 1'b1},
    '{4'h6, 2'd1, 1'b1, 16'hc35a, 1'b0, 1'b1},
    '{4'hc, 2'd0, 1'b0, 16'h2b2b, 1'b1, 1'b0}
  };
  // Beat held between table passes
  localparam row_t HOLD_ROW = '{4'h3, 2'd1, 1'b1, 16'h5aa5, 1'b1, 1'b1};

  logic                clk_wr = 1'b0;
  logic                reset, tx_online, rx_online;
  logic [3:0]          dstrm_state, ustrm_state;
  logic [1:0]          dstrm_protid, ustrm_protid;
  logic [DATA_W-1:0]   dstrm_data, ustrm_data, hold_data;
  logic                dstrm_dvalid, dstrm_crc_valid, dstrm_valid;
  logic                ustrm_dvalid, ustrm_crc_valid, ustrm_valid;
  logic [15:0]         dstrm_crc, ustrm_crc;
  logic [MRK_W-1:0]    tx_mrk_userbit;
  logic                tx_stb_userbit;
  logic [7:0]          delay_x_value, delay_xz_value, delay_yz_value;
  logic [31:0]         lfsr_state = 32'h5689_d911;
  wire  [PHY_W-1:0]    phy0, phy1, phy2, phy3;

  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  // Each lane loops straight back
  lpif_link_top DUT (
    .*,
    .tx_phy0(phy0), .tx_phy1(phy1), .tx_phy2(phy2), .tx_phy3(phy3),
    .rx_phy0(phy0), .rx_phy1(phy1), .rx_phy2(phy2), .rx_phy3(phy3)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per data bit
  function automatic logic [DATA_W-1:0] random_data();
    logic [DATA_W-1:0] d;
    d = '0;
    for (int b = 0; b < DATA_W; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      d[b] = lfsr_state[0];
    end
    return d;
  endfunction

  // Link word fields from state at the top down to valid
  function automatic logic [WORD_W-1:0] link_word(input row_t r, input logic [DATA_W-1:0] d);
    return {r.state, r.protid, d, r.dvalid, r.crc, r.crc_valid, r.valid};
  endfunction

  // Strobe on top, marker below, slice k of the zero-padded word at the bottom
  function automatic logic [PHY_W-1:0] expected_lane(input logic [WORD_W-1:0] word,
                                                     input int k);
    logic [SPAN_W-1:0] span;
    span = '0;
    span[WORD_W-1:0] = word;
    return {tx_stb_userbit, tx_mrk_userbit, span[k*PAY_W +: PAY_W]};
  endfunction

  function automatic logic [PHY_W-1:0] lane_value(input int k);
    case (k)
      0:       return phy0;
      1:       return phy1;
      2:       return phy2;
      default: return phy3;
    endcase
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic fail_value(input string name, input logic [127:0] exp,
                            input logic [127:0] act);
    abort_run($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act));
  endtask

  task automatic check_ustrm(input string name, input logic [WORD_W-1:0] exp);
    logic [WORD_W-1:0] act;
    act = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid, ustrm_crc,
           ustrm_crc_valid, ustrm_valid};
    assert (act === exp) else fail_value({name, " ustrm"}, 128'(exp), 128'(act));
  endtask

  // Zero lanes expected when quiet is set
  task automatic check_lanes(input string name, input logic [WORD_W-1:0] word,
                             input logic quiet);
    logic [PHY_W-1:0] exp;
    for (int k = 0; k < `LPIF_LANES; k++) begin
      exp = quiet ? '0 : expected_lane(word, k);
      assert (lane_value(k) === exp)
        else fail_value($sformatf("%s lane %0d", name, k), 128'(exp), 128'(lane_value(k)));
    end
  endtask

  task automatic next_step();
    @(posedge clk_wr);
    #DRIVE_DLY;
  endtask

  task automatic drive_row(input row_t r, input logic [DATA_W-1:0] d);
    dstrm_state     = r.state;
    dstrm_protid    = r.protid;
    dstrm_data      = d;
    dstrm_dvalid    = r.dvalid;
    dstrm_crc       = r.crc;
    dstrm_crc_valid = r.crc_valid;
    dstrm_valid     = r.valid;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test phases

  // Step 1 is the first edge that samples a raised online input
  // tx_online_delay rises after step XZ+2 and the lanes follow one step later
  // rx_online_delay rises after step X+YZ+2 and ustrm follows one step later
  // Looped words reach ustrm two steps after the lanes
  task automatic check_ramp(input string name, input logic raise_tx, input logic raise_rx);
    logic exp_lanes;
    logic exp_valid;
    if (raise_tx) begin
      tx_online = 1'b1;
    end
    if (raise_rx) begin
      rx_online = 1'b1;
    end
    for (int k = 1; k <= RAMP_STEPS; k++) begin
      next_step();
      exp_lanes = !raise_tx || (k >= DLY_XZ + 3);
      exp_valid = (!raise_tx || (k >= DLY_XZ + 5)) &&
                  (!raise_rx || (k >= DLY_X + DLY_YZ + 3));
      check_lanes(name, link_word(HOLD_ROW, hold_data), !exp_lanes);
      check_ustrm(name, exp_valid ? link_word(HOLD_ROW, hold_data) : '0);
    end
  endtask

  // Row i checked on the lanes two steps later, on ustrm four steps later
  task automatic run_pass(input string name, input logic [MRK_W-1:0] mrk, input logic stb);
    logic [DATA_W-1:0] data [NUM_ROWS];
    for (int i = 0; i < NUM_ROWS; i++) begin
      data[i] = random_data();
    end
    tx_mrk_userbit = mrk;
    tx_stb_userbit = stb;
    repeat (3) next_step();
    for (int i = 0; i < NUM_ROWS + 4; i++) begin
      next_step();
      if (i >= 4) begin
        check_ustrm(name, link_word(ROWS[i-4], data[i-4]));
      end
      if (i >= 2 && i < NUM_ROWS + 2) begin
        check_lanes(name, link_word(ROWS[i-2], data[i-2]), 1'b0);
      end
      if (i < NUM_ROWS) begin
        drive_row(ROWS[i], data[i]);
      end else begin
        drive_row(HOLD_ROW, hold_data);
      end
    end
  endtask

  // Old value on the first edge after the drop, zero from the second on
  task automatic check_drop(input string name, input logic tx_side);
    if (tx_side) begin
      tx_online = 1'b0;
    end else begin
      rx_online = 1'b0;
    end
    for (int k = 1; k <= 4; k++) begin
      next_step();
      if (tx_side) begin
        check_lanes(name, link_word(HOLD_ROW, hold_data), k >= 2);
      end else begin
        check_ustrm(name, (k >= 2) ? '0 : link_word(HOLD_ROW, hold_data));
      end
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run($sformatf("Watchdog timeout, run not finished after %0d ns", WATCHDOG_NS));
  end

  initial begin
    reset          = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    tx_mrk_userbit = 2'b01;
    tx_stb_userbit = 1'b1;
    delay_x_value  = 8'(DLY_X);
    delay_xz_value = 8'(DLY_XZ);
    delay_yz_value = 8'(DLY_YZ);
    drive_row('0, '0);
    hold_data = random_data();
    repeat (8) @(posedge clk_wr);
    #DRIVE_DLY;
    reset = 1'b0;

    // Everything quiet out of reset
    for (int k = 0; k < 3; k++) begin
      check_lanes("reset", '0, 1'b1);
      check_ustrm("reset", '0);
      next_step();
    end

    drive_row(HOLD_ROW, hold_data);
    check_ramp("online ramp", 1'b1, 1'b1);

    // Two user-bit settings over the table
    run_pass("loopback mrk 2 stb 1", 2'b10, 1'b1);
    run_pass("loopback mrk 3 stb 0", 2'b11, 1'b0);

    tx_mrk_userbit = 2'b01;
    tx_stb_userbit = 1'b1;
    repeat (5) next_step();

    // Each side taken down and brought back while the other stays online
    check_drop("rx offline", 1'b0);
    check_ramp("rx online again", 1'b0, 1'b1);
    check_drop("tx offline", 1'b1);
    check_ramp("tx online again", 1'b1, 1'b0);

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== lpif_link.f ====
+incdir+include
source/lpif_link_pkg.sv
source/lpif_link_user_if.sv
source/lpif_link_auto_sync.sv
source/lpif_link_concat.sv
source/lpif_link_top.sv
bench/lpif_link_assertions.sv
bench/lpif_link_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := lpif_link_tb
FILELIST  := lpif_link.f
FLAGS     := --binary --timing --assert --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
